// ==== files.f ====
+incdir+source
source/cdma_pkg.sv
source/cdma_burst_planner.sv
source/cdma_write_channel.sv
source/cdma_read_channel.sv
source/cdma_top.sv
testbench/tb_axi_mem.sv
testbench/tb_cdma.sv

// ==== source/cdma_burst_planner.sv ====
`default_nettype none
`include "cdma_consts.svh"

module cdma_burst_planner (
    input  wire logic            M_AXI_ACLK,        // AXI clock
    input  wire logic            M_AXI_ARESETN,     // Sync reset, active low
    input  wire logic            i_start,           // Command accepted
    input  wire cdma_pkg::addr_t i_start_addr,      // First word address
    input  wire cdma_pkg::size_t i_size,            // Beats in transfer
    input  wire logic            i_plan,            // Latch next burst length
    input  wire logic            i_beat,            // Data handshake
    output cdma_pkg::addr_t      o_addr,            // Current burst address
    output cdma_pkg::len_t       o_len,             // AxLEN of current burst
    output logic                 o_burst_end,       // Presented beat closes burst
    output logic                 o_xfer_end         // Presented beat closes transfer
);
    import cdma_pkg::*;

    addr_t addr_q;          // Running burst address
    size_t remain_q;        // Beats still to move
    len_t  len_q;           // Burst beats minus one
    len_t  beat_cnt_q;      // Beats done in this burst
    addr_t burst_bytes;     // Address step per burst
    logic  cap;             // More left than one burst holds

    assign cap         = (remain_q > size_t'(`CDMA_MAX_BURST));
    assign burst_bytes = (addr_t'(len_q) + 1'b1) * addr_t'(`CDMA_BYTES);

    // Counter decode, consumed only together with a beat
    assign o_burst_end = (beat_cnt_q == len_q);
    assign o_xfer_end  = (remain_q == size_t'(1));

    assign o_addr = addr_q;
    assign o_len  = len_q;

    // Remaining and in-burst counters
    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            remain_q   <= '0;
            beat_cnt_q <= '0;
        end else begin
            if (i_start) begin
                remain_q <= i_size;                     // Whole transfer
            end else if (i_beat) begin
                remain_q <= remain_q - 1'b1;
            end
            if (i_plan) begin
                beat_cnt_q <= '0;                       // Fresh burst
            end else if (i_beat) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
        end
    end

    // Address and length, held for the whole burst
    always_ff @(posedge M_AXI_ACLK) begin
        if (i_start) begin
            addr_q <= i_start_addr;
        end else if (i_beat && o_burst_end) begin
            addr_q <= addr_q + burst_bytes;             // Skip past moved words
        end
        if (i_plan) begin
            if (cap) begin
                len_q <= len_t'(`CDMA_MAX_BURST - 1);   // Full burst
            end else begin
                len_q <= len_t'(remain_q - 1'b1);       // Tail burst
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/cdma_consts.svh ====
`ifndef CDMA_CONSTS_SVH
`define CDMA_CONSTS_SVH

// Bus widths
`define CDMA_ADDR_W     32      // Byte address
`define CDMA_DATA_W     32      // One data word
`define CDMA_BYTES      4       // Bytes per word

// Transfer sizing
`define CDMA_SIZE_W     16      // Beat count of one command
`define CDMA_MAX_BURST  16      // Longest burst, 256 or less
`define CDMA_LEN_W      8       // AXI AxLEN field

// Fixed AXI fields
`define CDMA_AXSIZE     3'd2    // log2 of CDMA_BYTES
`define CDMA_AXCACHE    4'b0010 // Normal non-cacheable, non-bufferable

`endif

// ==== source/cdma_pkg.sv ====
`default_nettype none
`include "cdma_consts.svh"

package cdma_pkg;

    typedef logic [`CDMA_ADDR_W-1:0] addr_t;    // Byte address
    typedef logic [`CDMA_DATA_W-1:0] data_t;    // Stream word
    typedef logic [`CDMA_SIZE_W-1:0] size_t;    // Beats per command
    typedef logic [`CDMA_LEN_W-1:0]  len_t;     // Beats minus one

    // AxBURST encodings
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    // Per-direction channel FSM
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,     // Waiting for a command
        ST_PLAN = 2'd1,     // One cycle, length is latched
        ST_XFER = 2'd2      // Address and data phase
    } chan_state_e;

endpackage

`default_nettype wire

// ==== source/cdma_read_channel.sv ====
`default_nettype none

module cdma_read_channel (
    input  wire logic M_AXI_ACLK,           // AXI clock
    input  wire logic M_AXI_ARESETN,        // Sync reset, active low
    input  wire logic i_cdma_raddr_vld,     // Command pulse
    input  wire logic i_cdma_rready,        // User can take a word
    input  wire logic i_arready,            // AR slave ready
    input  wire logic i_rvalid,             // R beat present
    input  wire logic i_burst_end,          // Planner decode
    input  wire logic i_xfer_end,           // Planner decode
    output logic      o_cdma_rbusy,         // Transfer in progress
    output logic      o_cdma_rvalid,        // User word present
    output logic      o_arvalid,            // AR request
    output logic      o_rready,             // R beat taken
    output logic      o_start,              // Load planner
    output logic      o_plan,               // Size next burst
    output logic      o_beat                // R handshake
);
    import cdma_pkg::*;

    chan_state_e state_q;
    chan_state_e state_d;
    logic        xfer;          // Data phase

    assign xfer = (state_q == ST_XFER);

    assign o_start       = (state_q == ST_IDLE) && i_cdma_raddr_vld;
    assign o_plan        = (state_q == ST_PLAN);
    assign o_cdma_rbusy  = (state_q != ST_IDLE);
    assign o_cdma_rvalid = i_rvalid && xfer;       // Only inside data phase
    assign o_rready      = i_cdma_rready && xfer;
    assign o_beat        = i_rvalid && o_rready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_cdma_raddr_vld) begin
                    state_d = ST_PLAN;
                end
            end
            ST_PLAN: state_d = ST_XFER;
            ST_XFER: begin
                // Beats counted locally, RLAST not trusted
                if (o_beat && i_burst_end) begin
                    state_d = i_xfer_end ? ST_IDLE : ST_PLAN;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            state_q   <= ST_IDLE;
            o_arvalid <= 1'b0;
        end else begin
            state_q <= state_d;
            if (o_plan) begin
                o_arvalid <= 1'b1;
            end else if (o_arvalid && i_arready) begin
                o_arvalid <= 1'b0;                         // Accepted
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/cdma_top.sv ====
`default_nettype none
`include "cdma_consts.svh"

module cdma_top (
    // User write side
    input  wire cdma_pkg::addr_t   i_cdma_waddr,        // Write start address
    input  wire logic              i_cdma_waddr_vld,    // Write command pulse
    input  wire cdma_pkg::size_t   i_cdma_wsize,        // Words to write, nonzero
    output logic                   o_cdma_wbusy,
    input  wire cdma_pkg::data_t   i_cdma_wdata,
    output logic                   o_cdma_wready,
    input  wire logic              i_cdma_wvalid,
    // User read side
    input  wire cdma_pkg::addr_t   i_cdma_raddr,        // Read start address
    input  wire logic              i_cdma_raddr_vld,    // Read command pulse
    input  wire cdma_pkg::size_t   i_cdma_rsize,        // Words to read, nonzero
    output logic                   o_cdma_rbusy,
    output cdma_pkg::data_t        o_cdma_rdata,
    input  wire logic              i_cdma_rready,
    output logic                   o_cdma_rvalid,
    // AXI4 master
    input  wire logic              M_AXI_ACLK,
    input  wire logic              M_AXI_ARESETN,
    output logic [0:0]             M_AXI_AWID,
    output cdma_pkg::addr_t        M_AXI_AWADDR,
    output cdma_pkg::len_t         M_AXI_AWLEN,
    output logic [2:0]             M_AXI_AWSIZE,
    output logic [1:0]             M_AXI_AWBURST,
    output logic                   M_AXI_AWLOCK,
    output logic [3:0]             M_AXI_AWCACHE,
    output logic [2:0]             M_AXI_AWPROT,
    output logic [3:0]             M_AXI_AWQOS,
    output logic                   M_AXI_AWVALID,
    input  wire logic              M_AXI_AWREADY,
    output logic [0:0]             M_AXI_WID,
    output cdma_pkg::data_t        M_AXI_WDATA,
    output logic [`CDMA_BYTES-1:0] M_AXI_WSTRB,
    output logic                   M_AXI_WLAST,
    output logic                   M_AXI_WVALID,
    input  wire logic              M_AXI_WREADY,
    input  wire logic [0:0]        M_AXI_BID,           // Response not checked
    input  wire logic [1:0]        M_AXI_BRESP,
    input  wire logic              M_AXI_BVALID,
    output logic                   M_AXI_BREADY,
    output logic [0:0]             M_AXI_ARID,
    output cdma_pkg::addr_t        M_AXI_ARADDR,
    output cdma_pkg::len_t         M_AXI_ARLEN,
    output logic [2:0]             M_AXI_ARSIZE,
    output logic [1:0]             M_AXI_ARBURST,
    output logic                   M_AXI_ARLOCK,
    output logic [3:0]             M_AXI_ARCACHE,
    output logic [2:0]             M_AXI_ARPROT,
    output logic [3:0]             M_AXI_ARQOS,
    output logic                   M_AXI_ARVALID,
    input  wire logic              M_AXI_ARREADY,
    input  wire logic [0:0]        M_AXI_RID,           // Beats counted locally
    input  wire cdma_pkg::data_t   M_AXI_RDATA,
    input  wire logic [1:0]        M_AXI_RRESP,
    input  wire logic              M_AXI_RLAST,
    input  wire logic              M_AXI_RVALID,
    output logic                   M_AXI_RREADY
);
    import cdma_pkg::*;

    logic wstart, wplan, wbeat;     // Write channel to planner
    logic wburst_end, wxfer_end;    // Write planner to channel
    logic rstart, rplan, rbeat;
    logic rburst_end, rxfer_end;

    // Fixed AW/W/B fields
    assign M_AXI_AWID    = '0;
    assign M_AXI_AWSIZE  = `CDMA_AXSIZE;
    assign M_AXI_AWBURST = INCR;
    assign M_AXI_AWLOCK  = 1'b0;
    assign M_AXI_AWCACHE = `CDMA_AXCACHE;
    assign M_AXI_AWPROT  = 3'b000;
    assign M_AXI_AWQOS   = 4'h0;
    assign M_AXI_WID     = '0;
    assign M_AXI_WSTRB   = {`CDMA_BYTES{1'b1}};    // Every lane written
    assign M_AXI_WDATA   = i_cdma_wdata;
    assign M_AXI_BREADY  = 1'b1;                   // Responses always drained

    // Fixed AR fields
    assign M_AXI_ARID    = '0;
    assign M_AXI_ARSIZE  = `CDMA_AXSIZE;
    assign M_AXI_ARBURST = INCR;
    assign M_AXI_ARLOCK  = 1'b0;
    assign M_AXI_ARCACHE = `CDMA_AXCACHE;
    assign M_AXI_ARPROT  = 3'b000;
    assign M_AXI_ARQOS   = 4'h0;
    assign o_cdma_rdata  = M_AXI_RDATA;            // Straight through

    cdma_burst_planner u_wplan (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_start       (wstart),
        .i_start_addr  (i_cdma_waddr),
        .i_size        (i_cdma_wsize),
        .i_plan        (wplan),
        .i_beat        (wbeat),
        .o_addr        (M_AXI_AWADDR),
        .o_len         (M_AXI_AWLEN),
        .o_burst_end   (wburst_end),
        .o_xfer_end    (wxfer_end)
    );

    cdma_write_channel u_wchan (
        .M_AXI_ACLK       (M_AXI_ACLK),
        .M_AXI_ARESETN    (M_AXI_ARESETN),
        .i_cdma_waddr_vld (i_cdma_waddr_vld),
        .i_cdma_wvalid    (i_cdma_wvalid),
        .i_awready        (M_AXI_AWREADY),
        .i_wready         (M_AXI_WREADY),
        .i_burst_end      (wburst_end),
        .i_xfer_end       (wxfer_end),
        .o_cdma_wbusy     (o_cdma_wbusy),
        .o_cdma_wready    (o_cdma_wready),
        .o_awvalid        (M_AXI_AWVALID),
        .o_wvalid         (M_AXI_WVALID),
        .o_wlast          (M_AXI_WLAST),
        .o_start          (wstart),
        .o_plan           (wplan),
        .o_beat           (wbeat)
    );

    cdma_burst_planner u_rplan (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_start       (rstart),
        .i_start_addr  (i_cdma_raddr),
        .i_size        (i_cdma_rsize),
        .i_plan        (rplan),
        .i_beat        (rbeat),
        .o_addr        (M_AXI_ARADDR),
        .o_len         (M_AXI_ARLEN),
        .o_burst_end   (rburst_end),
        .o_xfer_end    (rxfer_end)
    );

    cdma_read_channel u_rchan (
        .M_AXI_ACLK       (M_AXI_ACLK),
        .M_AXI_ARESETN    (M_AXI_ARESETN),
        .i_cdma_raddr_vld (i_cdma_raddr_vld),
        .i_cdma_rready    (i_cdma_rready),
        .i_arready        (M_AXI_ARREADY),
        .i_rvalid         (M_AXI_RVALID),
        .i_burst_end      (rburst_end),
        .i_xfer_end       (rxfer_end),
        .o_cdma_rbusy     (o_cdma_rbusy),
        .o_cdma_rvalid    (o_cdma_rvalid),
        .o_arvalid        (M_AXI_ARVALID),
        .o_rready         (M_AXI_RREADY),
        .o_start          (rstart),
        .o_plan           (rplan),
        .o_beat           (rbeat)
    );

endmodule

`default_nettype wire

// ==== source/cdma_write_channel.sv ====
`default_nettype none

module cdma_write_channel (
    input  wire logic M_AXI_ACLK,           // AXI clock
    input  wire logic M_AXI_ARESETN,        // Sync reset, active low
    input  wire logic i_cdma_waddr_vld,     // Command pulse
    input  wire logic i_cdma_wvalid,        // User word present
    input  wire logic i_awready,            // AW slave ready
    input  wire logic i_wready,             // W slave ready
    input  wire logic i_burst_end,          // Planner decode
    input  wire logic i_xfer_end,           // Planner decode
    output logic      o_cdma_wbusy,         // Transfer in progress
    output logic      o_cdma_wready,        // User word taken
    output logic      o_awvalid,            // AW request
    output logic      o_wvalid,             // W beat present
    output logic      o_wlast,              // Final beat of burst
    output logic      o_start,              // Load planner
    output logic      o_plan,               // Size next burst
    output logic      o_beat                // W handshake
);
    import cdma_pkg::*;

    chan_state_e state_q;
    chan_state_e state_d;
    logic        xfer;          // Data phase
    logic        hold_last;     // Closing beat waits for AW

    assign xfer      = (state_q == ST_XFER);
    // AWADDR must stay put until accepted, so the burst cannot close early
    assign hold_last = i_burst_end && o_awvalid;

    assign o_start       = (state_q == ST_IDLE) && i_cdma_waddr_vld;
    assign o_plan        = (state_q == ST_PLAN);
    assign o_cdma_wbusy  = (state_q != ST_IDLE);
    assign o_wvalid      = i_cdma_wvalid && xfer && !hold_last;
    assign o_cdma_wready = i_wready && xfer && !hold_last;     // Mirrors WVALID gating
    assign o_beat        = o_wvalid && i_wready;
    assign o_wlast       = o_wvalid && i_burst_end;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_cdma_waddr_vld) begin
                    state_d = ST_PLAN;
                end
            end
            ST_PLAN: state_d = ST_XFER;                    // Single cycle
            ST_XFER: begin
                if (o_beat && i_burst_end) begin
                    state_d = i_xfer_end ? ST_IDLE : ST_PLAN;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            state_q   <= ST_IDLE;
            o_awvalid <= 1'b0;
        end else begin
            state_q <= state_d;
            if (o_plan) begin
                o_awvalid <= 1'b1;                         // Up on first XFER cycle
            end else if (o_awvalid && i_awready) begin
                o_awvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_axi_mem.sv ====
`default_nettype none

module tb_axi_mem (
    input  wire logic            M_AXI_ACLK,        // Shared clock
    input  wire logic            M_AXI_ARESETN,     // Sync reset, active low
    input  wire logic            i_awvalid,
    input  wire cdma_pkg::addr_t i_awaddr,
    output logic                 o_awready,
    input  wire logic            i_wvalid,
    input  wire cdma_pkg::data_t i_wdata,
    input  wire logic            i_wlast,
    output logic                 o_wready,
    output logic                 o_bvalid,          // One pulse per write burst
    input  wire logic            i_arvalid,
    input  wire cdma_pkg::addr_t i_araddr,
    input  wire cdma_pkg::len_t  i_arlen,
    output logic                 o_arready,
    output logic                 o_rvalid,
    output cdma_pkg::data_t      o_rdata,
    output logic                 o_rlast,
    input  wire logic            i_rready
);
    timeunit 1ns;
    timeprecision 100ps;
    import cdma_pkg::*;

    data_t mem [0:1023];    // Word array, byte address bits 11:2
    logic  run;             // Out of reset at the last edge
    logic  aw_act;          // Write burst accepted, data pending
    logic  ar_act;          // Read burst accepted, data pending
    logic  r_hold;          // Beat offered but not taken
    logic  b_due;           // Write burst closed on the last edge
    addr_t aw_addr;         // Next word to write
    addr_t ar_addr;         // Next word to read
    len_t  ar_left;         // Beats after the current one

    initial begin
        o_awready = 1'b0;
        o_wready  = 1'b0;
        o_bvalid  = 1'b0;
        o_arready = 1'b0;
        o_rvalid  = 1'b0;
        o_rdata   = '0;
        o_rlast   = 1'b0;
    end

    // Handshakes taken on the edge, new ready and data 1 ns later
    always @(posedge M_AXI_ACLK) begin
        run    = M_AXI_ARESETN;
        b_due  = 1'b0;
        r_hold = 1'b0;
        if (!run) begin
            aw_act = 1'b0;
            ar_act = 1'b0;
        end else begin
            r_hold = o_rvalid && !i_rready;            // RVALID must stay up
            if (i_awvalid && o_awready) begin
                aw_act  = 1'b1;
                aw_addr = i_awaddr;
            end
            if (i_wvalid && o_wready) begin
                mem[aw_addr[11:2]] = i_wdata;
                aw_addr = aw_addr + 4;
                aw_act  = !i_wlast;                    // WLAST closes the burst
                b_due   = i_wlast;
            end
            if (o_rvalid && i_rready) begin
                ar_addr = ar_addr + 4;
                ar_act  = (ar_left != 0);
                ar_left = ar_left - 1'b1;
            end
            if (i_arvalid && o_arready) begin
                ar_act  = 1'b1;                        // One read burst at a time
                ar_addr = i_araddr;
                ar_left = i_arlen;
            end
        end
        #1;
        o_awready = run && !aw_act && (($urandom % 4) != 0);
        o_wready  = run && aw_act && (($urandom % 4) != 0);   // W only after AW
        o_bvalid  = b_due;
        o_arready = run && !ar_act && (($urandom % 4) != 0);
        if (!r_hold) begin
            o_rvalid = run && ar_act && (($urandom % 4) != 0);
        end
        o_rdata = mem[ar_addr[11:2]];
        o_rlast = (ar_left == 0);
    end

endmodule

`default_nettype wire

// ==== testbench/tb_cdma.sv ====
`default_nettype none
`include "cdma_consts.svh"

module tb_cdma;
    timeunit 1ns;
    timeprecision 100ps;
    import cdma_pkg::*;

    localparam int    TIMEOUT_CYCLES = 4000;    // About 160 beats at 4 cycles, plus overhead
    localparam int    N_WORDS        = 40;      // Bursts of 16, 16 and 8
    localparam addr_t WR_BASE        = 32'h100;

    logic       M_AXI_ACLK = 1'b0;
    logic       M_AXI_ARESETN;
    addr_t      i_cdma_waddr, i_cdma_raddr, M_AXI_AWADDR, M_AXI_ARADDR;
    size_t      i_cdma_wsize, i_cdma_rsize;
    data_t      i_cdma_wdata, o_cdma_rdata, M_AXI_WDATA, M_AXI_RDATA;
    len_t       M_AXI_AWLEN, M_AXI_ARLEN;
    logic       i_cdma_waddr_vld, i_cdma_raddr_vld, i_cdma_wvalid, i_cdma_rready;
    logic       o_cdma_wbusy, o_cdma_rbusy, o_cdma_wready, o_cdma_rvalid;
    logic [0:0] M_AXI_AWID, M_AXI_WID, M_AXI_BID, M_AXI_ARID, M_AXI_RID;
    logic [1:0] M_AXI_AWBURST, M_AXI_ARBURST, M_AXI_BRESP, M_AXI_RRESP;
    logic [2:0] M_AXI_AWSIZE, M_AXI_ARSIZE, M_AXI_AWPROT, M_AXI_ARPROT;
    logic [3:0] M_AXI_AWCACHE, M_AXI_ARCACHE, M_AXI_AWQOS, M_AXI_ARQOS;
    logic [`CDMA_BYTES-1:0] M_AXI_WSTRB;
    logic       M_AXI_AWLOCK, M_AXI_ARLOCK, M_AXI_AWVALID, M_AXI_AWREADY, M_AXI_BREADY;
    logic       M_AXI_WLAST, M_AXI_WVALID, M_AXI_WREADY, M_AXI_BVALID;
    logic       M_AXI_ARVALID, M_AXI_ARREADY, M_AXI_RLAST, M_AXI_RVALID, M_AXI_RREADY;

    data_t words [0:N_WORDS-1];     // Stimulus, also the read-back reference
    size_t aw_left, ar_left;        // Beats not yet covered by an address
    addr_t aw_next, ar_next;        // Expected next burst address
    size_t w_len, w_cnt;            // Current W burst length, beats seen in it
    size_t w_done, w_size;          // User write beats against command size
    size_t r_done, r_size;
    logic  cmd_seen;                // First command driven
    int    cycles = 0;

    assign M_AXI_BID   = 1'b0;      // Response sidebands, ignored by the DUT
    assign M_AXI_BRESP = 2'b00;
    assign M_AXI_RID   = 1'b0;
    assign M_AXI_RRESP = 2'b00;

    cdma_top u_cdma_top (.*);

    tb_axi_mem u_mem (
        .M_AXI_ACLK    (M_AXI_ACLK),
        .M_AXI_ARESETN (M_AXI_ARESETN),
        .i_awvalid     (M_AXI_AWVALID),
        .i_awaddr      (M_AXI_AWADDR),
        .o_awready     (M_AXI_AWREADY),
        .i_wvalid      (M_AXI_WVALID),
        .i_wdata       (M_AXI_WDATA),
        .i_wlast       (M_AXI_WLAST),
        .o_wready      (M_AXI_WREADY),
        .o_bvalid      (M_AXI_BVALID),
        .i_arvalid     (M_AXI_ARVALID),
        .i_araddr      (M_AXI_ARADDR),
        .i_arlen       (M_AXI_ARLEN),
        .o_arready     (M_AXI_ARREADY),
        .o_rvalid      (M_AXI_RVALID),
        .o_rdata       (M_AXI_RDATA),
        .o_rlast       (M_AXI_RLAST),
        .i_rready      (M_AXI_RREADY)
    );

    always #5 M_AXI_ACLK = ~M_AXI_ACLK;        // 10 ns period

    // Beats in the next burst
    function automatic size_t burst_beats(input size_t left);
        return (left > `CDMA_MAX_BURST) ? size_t'(`CDMA_MAX_BURST) : left;
    endfunction

    task automatic stop_with(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    always @(posedge M_AXI_ACLK) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            stop_with("Run timed out before the transfers finished");
        end
    end

    // Reference counters, loaded when a command is taken in idle
    always @(posedge M_AXI_ACLK) begin
        if (!M_AXI_ARESETN) begin
            aw_left <= '0;
            ar_left <= '0;
            aw_next <= '0;
            ar_next <= '0;
            w_len   <= '0;
            w_cnt   <= '0;
            w_done  <= '0;
            w_size  <= '0;
            r_done  <= '0;
            r_size  <= '0;
        end else begin
            if (i_cdma_waddr_vld && !o_cdma_wbusy) begin
                aw_left <= i_cdma_wsize;
                aw_next <= i_cdma_waddr;
                w_done  <= '0;
                w_size  <= i_cdma_wsize;
            end
            if (i_cdma_raddr_vld && !o_cdma_rbusy) begin
                ar_left <= i_cdma_rsize;
                ar_next <= i_cdma_raddr;
                r_done  <= '0;
                r_size  <= i_cdma_rsize;
            end
            if (M_AXI_AWVALID && M_AXI_AWREADY) begin
                aw_left <= aw_left - burst_beats(aw_left);
                aw_next <= aw_next + `CDMA_BYTES * burst_beats(aw_left);
                w_len   <= burst_beats(aw_left);
            end
            if (M_AXI_ARVALID && M_AXI_ARREADY) begin
                ar_left <= ar_left - burst_beats(ar_left);
                ar_next <= ar_next + `CDMA_BYTES * burst_beats(ar_left);
            end
            if (M_AXI_WVALID && M_AXI_WREADY) begin
                w_cnt <= (w_cnt + 1'b1 == w_len) ? '0 : w_cnt + 1'b1;
            end
            if (i_cdma_wvalid && o_cdma_wready) w_done <= w_done + 1'b1;
            if (o_cdma_rvalid && i_cdma_rready) r_done <= r_done + 1'b1;
        end
    end

    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        cmd_seen || !(o_cdma_wbusy || o_cdma_rbusy || M_AXI_AWVALID || M_AXI_ARVALID
                      || M_AXI_WVALID || o_cdma_rvalid || o_cdma_wready || M_AXI_RREADY))
        else stop_with($sformatf("Mismatch idle busy/valid/ready: got %h exp 00",
            $sampled({o_cdma_wbusy, o_cdma_rbusy, M_AXI_AWVALID, M_AXI_ARVALID,
                      M_AXI_WVALID, o_cdma_rvalid, o_cdma_wready, M_AXI_RREADY})));
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        M_AXI_AWSIZE == $clog2(`CDMA_BYTES) && M_AXI_ARSIZE == $clog2(`CDMA_BYTES))
        else stop_with($sformatf("Mismatch AWSIZE/ARSIZE: got %h/%h exp %h",
            $sampled(M_AXI_AWSIZE), $sampled(M_AXI_ARSIZE), $clog2(`CDMA_BYTES)));
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        M_AXI_AWBURST == 2'b01 && M_AXI_ARBURST == 2'b01)
        else stop_with($sformatf("Mismatch AWBURST/ARBURST: got %h/%h exp 1",
            $sampled(M_AXI_AWBURST), $sampled(M_AXI_ARBURST)));
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        M_AXI_WSTRB == '1)
        else stop_with($sformatf("Mismatch WSTRB: got %h exp f", $sampled(M_AXI_WSTRB)));
    // IDs, lock, prot and qos all zero
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        {M_AXI_AWID, M_AXI_WID, M_AXI_ARID, M_AXI_AWLOCK, M_AXI_ARLOCK,
         M_AXI_AWPROT, M_AXI_ARPROT, M_AXI_AWQOS, M_AXI_ARQOS} == '0)
        else stop_with($sformatf("Mismatch AxID/WID/AxLOCK/AxPROT/AxQOS: got %h exp 0",
            $sampled({M_AXI_AWID, M_AXI_WID, M_AXI_ARID, M_AXI_AWLOCK, M_AXI_ARLOCK,
                      M_AXI_AWPROT, M_AXI_ARPROT, M_AXI_AWQOS, M_AXI_ARQOS})));
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        M_AXI_AWCACHE == 4'b0010 && M_AXI_ARCACHE == 4'b0010)
        else stop_with($sformatf("Mismatch AWCACHE/ARCACHE: got %h/%h exp 2",
            $sampled(M_AXI_AWCACHE), $sampled(M_AXI_ARCACHE)));
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        M_AXI_BREADY)
        else stop_with($sformatf("Mismatch BREADY: got %h exp 1", $sampled(M_AXI_BREADY)));
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        (M_AXI_AWVALID && M_AXI_AWREADY) |-> size_t'(M_AXI_AWLEN) + 1'b1 == burst_beats(aw_left))
        else stop_with($sformatf("Mismatch AWLEN+1: got %h exp %h",
            $sampled(M_AXI_AWLEN) + 1, burst_beats($sampled(aw_left))));
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        (M_AXI_AWVALID && M_AXI_AWREADY) |-> M_AXI_AWADDR == aw_next)
        else stop_with($sformatf("Mismatch AWADDR: got %h exp %h",
            $sampled(M_AXI_AWADDR), $sampled(aw_next)));
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        (M_AXI_ARVALID && M_AXI_ARREADY) |-> size_t'(M_AXI_ARLEN) + 1'b1 == burst_beats(ar_left))
        else stop_with($sformatf("Mismatch ARLEN+1: got %h exp %h",
            $sampled(M_AXI_ARLEN) + 1, burst_beats($sampled(ar_left))));
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        (M_AXI_ARVALID && M_AXI_ARREADY) |-> M_AXI_ARADDR == ar_next)
        else stop_with($sformatf("Mismatch ARADDR: got %h exp %h",
            $sampled(M_AXI_ARADDR), $sampled(ar_next)));
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        (M_AXI_WVALID && M_AXI_WREADY) |-> M_AXI_WLAST == (w_cnt + 1'b1 == w_len))
        else stop_with($sformatf("Mismatch WLAST: got %h exp %h",
            $sampled(M_AXI_WLAST), $sampled(w_cnt + 1'b1 == w_len)));
    // AXI beat and user beat are the same event in both directions
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        (M_AXI_WVALID && M_AXI_WREADY) == (i_cdma_wvalid && o_cdma_wready))
        else stop_with($sformatf("Mismatch W beat vs o_cdma_wready beat: got %h exp %h",
            $sampled(M_AXI_WVALID && M_AXI_WREADY),
            $sampled(i_cdma_wvalid && o_cdma_wready)));
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        (M_AXI_RVALID && M_AXI_RREADY) == (o_cdma_rvalid && i_cdma_rready))
        else stop_with($sformatf("Mismatch M_AXI_RREADY beat vs user beat: got %h exp %h",
            $sampled(M_AXI_RVALID && M_AXI_RREADY),
            $sampled(o_cdma_rvalid && i_cdma_rready)));
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        (M_AXI_WVALID && M_AXI_WREADY) |-> M_AXI_WDATA == words[w_done])
        else stop_with($sformatf("Mismatch M_AXI_WDATA: got %h exp %h",
            $sampled(M_AXI_WDATA), words[$sampled(w_done)]));
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        (o_cdma_rvalid && i_cdma_rready) |-> o_cdma_rdata == words[r_done])
        else stop_with($sformatf("Mismatch o_cdma_rdata: got %h exp %h",
            $sampled(o_cdma_rdata), words[$sampled(r_done)]));
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        $fell(o_cdma_wbusy) |-> w_done == w_size)
        else stop_with($sformatf("Mismatch write beats at o_cdma_wbusy fall: got %h exp %h",
            $sampled(w_done), $sampled(w_size)));
    assert property (@(posedge M_AXI_ACLK) disable iff (!M_AXI_ARESETN)
        $fell(o_cdma_rbusy) |-> r_done == r_size)
        else stop_with($sformatf("Mismatch read beats at o_cdma_rbusy fall: got %h exp %h",
            $sampled(r_done), $sampled(r_size)));

    // All stimulus tasks start and end 1 ns after a rising edge
    task automatic pulse_write_cmd(input addr_t addr, input size_t size);
        i_cdma_waddr     = addr;
        i_cdma_wsize     = size;
        i_cdma_waddr_vld = 1'b1;
        cmd_seen         = 1'b1;
        @(posedge M_AXI_ACLK);
        #1;
        i_cdma_waddr_vld = 1'b0;
    endtask

    task automatic pulse_read_cmd(input addr_t addr, input size_t size);
        i_cdma_raddr     = addr;
        i_cdma_rsize     = size;
        i_cdma_raddr_vld = 1'b1;
        cmd_seen         = 1'b1;
        @(posedge M_AXI_ACLK);
        #1;
        i_cdma_raddr_vld = 1'b0;
    endtask

    task automatic run_write(input addr_t addr, input size_t size);
        int i;
        pulse_write_cmd(addr, size);
        pulse_write_cmd(32'h300, 16'd3);           // Busy by now, must be dropped
        for (i = 0; i < size; i++) begin
            i_cdma_wdata  = words[i];
            i_cdma_wvalid = 1'b1;
            do @(posedge M_AXI_ACLK); while (!o_cdma_wready);
            #1;
        end
        i_cdma_wvalid = 1'b0;
        while (o_cdma_wbusy) begin
            @(posedge M_AXI_ACLK);
            #1;
        end
    endtask

    task automatic run_read(input addr_t addr, input size_t size);
        int got;
        got = 0;
        pulse_read_cmd(addr, size);
        pulse_read_cmd(32'h300, 16'd3);
        while (got < size) begin
            i_cdma_rready = ($urandom % 2) != 0;   // User back-pressure
            @(posedge M_AXI_ACLK);
            if (o_cdma_rvalid && i_cdma_rready) got++;
            #1;
        end
        i_cdma_rready = 1'b0;
        while (o_cdma_rbusy) begin
            @(posedge M_AXI_ACLK);
            #1;
        end
    endtask

    initial begin
        int i;
        void'($urandom(32'h26fa_0bb4));
        M_AXI_ARESETN    = 1'b0;
        i_cdma_waddr     = '0;
        i_cdma_wsize     = '0;
        i_cdma_waddr_vld = 1'b0;
        i_cdma_wdata     = '0;
        i_cdma_wvalid    = 1'b0;
        i_cdma_raddr     = '0;
        i_cdma_rsize     = '0;
        i_cdma_raddr_vld = 1'b0;
        i_cdma_rready    = 1'b0;
        cmd_seen         = 1'b0;
        for (i = 0; i < N_WORDS; i++) begin
            words[i] = $urandom;
        end
        repeat (10) @(posedge M_AXI_ACLK);
        #1;
        M_AXI_ARESETN = 1'b1;
        repeat (3) @(posedge M_AXI_ACLK);           // Quiet window after reset
        #1;
        run_write(WR_BASE, N_WORDS);
        run_read(WR_BASE, N_WORDS);                 // Reads start at the write base
        run_read(WR_BASE, 5);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
